// File: Bender.yml
package:
  name: elink_loop

sources:
  - include_dirs:
      - design
    files:
      - design/elink_pkg.sv
      - design/enc_8b10b.sv
      - design/eproc_out_enc.sv
      - design/elink_rx_dec.sv
      - design/elink_loop_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/elink_loop_chk.sv
      - verif/tb_elink_loop.sv

// File: design/elink_consts.svh
`ifndef ELINK_CONSTS_SVH
`define ELINK_CONSTS_SVH

// line bits per bit_clk
`define ELINK_W 2

// bits per 8b10b symbol
`define SYM_LEN 10

// bit_clk cycles per symbol slot
`define SYM_CYC 5

// control bytes
// comma, sent as idle fill
`define K28_5 8'hBC
// start of packet
`define K28_1 8'h3C
// end of packet
`define K28_6 8'hDC

`endif

// File: design/elink_loop_top.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module elink_loop_top (
  input  logic                   bit_clk,
  input  logic                   arst_n,
  input  elink_pkg::elink_word_t edata_in,
  input  logic                   data_rdy,
  input  logic                   reverse_10b,
  input  logic                   swap_bits,
  output logic                   get_data_trig,
  output logic [`ELINK_W-1:0]    edata_out,
  output logic                   rx_valid,
  output elink_pkg::rx_sym_t     rx_sym
);

  // transmitter, 8b10b serializer onto the 2-bit line
  eproc_out_enc u_tx (
    .bit_clk       (bit_clk),
    .arst_n        (arst_n),
    .edata_in      (edata_in),
    .data_rdy      (data_rdy),
    .reverse_10b   (reverse_10b),
    .swap_bits     (swap_bits),
    .get_data_trig (get_data_trig),
    .edata_out     (edata_out)
  );

  // link chip side, same line options as the transmitter
  elink_rx_dec u_rx (
    .bit_clk     (bit_clk),
    .arst_n      (arst_n),
    .edata_in    (edata_out),
    .reverse_10b (reverse_10b),
    .swap_bits   (swap_bits),
    .rx_valid    (rx_valid),
    .rx_sym      (rx_sym)
  );

endmodule

// File: design/elink_pkg.sv
package elink_pkg;

  // frame code in the upper two bits of the input word
  typedef enum logic [1:0] {
    CODE_DATA  = 2'b00,
    CODE_EOP   = 2'b01,
    CODE_SOP   = 2'b10,
    CODE_COMMA = 2'b11
  } frame_code_e;

  typedef struct packed {
    frame_code_e code;
    logic [7:0]  data;
  } elink_word_t;

  // receiver output, one per aligned symbol
  typedef struct packed {
    logic [7:0] data;
    logic       ko;
    logic       code_err;
    logic       disp_err;
  } rx_sym_t;

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;
  typedef enum logic {RX_HUNT, RX_LOCKED} rx_state_e;

  // 5b/6b table, rd- column, abcdei with a in bit 5
  localparam logic [5:0] ENC6_RDM [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b table, rd- column, fghj with f in bit 3, x.7 primary form
  localparam logic [3:0] ENC4_RDM [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

  // K28 6b group and x.7 alternate 4b group, rd- forms
  localparam logic [5:0] K28_6B = 6'b001111;
  localparam logic [3:0] A7_4B  = 4'b0111;

  // 6b groups whose form depends on running disparity
  // D.07 is balanced but still has two forms
  function automatic logic sym6_dep(input logic [4:0] x);
    return ($countones(ENC6_RDM[x]) != 3) || (x == 5'd7);
  endfunction

  // x.3 flips like the unbalanced groups
  function automatic logic sym4_dep(input logic [2:0] y);
    return !(y inside {3'd1, 3'd2, 3'd5, 3'd6});
  endfunction

endpackage

// File: design/elink_rx_dec.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module elink_rx_dec (
  input  logic                bit_clk,
  input  logic                arst_n,
  input  logic [`ELINK_W-1:0] edata_in,
  input  logic                reverse_10b,
  input  logic                swap_bits,
  output logic                rx_valid,
  output elink_pkg::rx_sym_t  rx_sym
);
  import elink_pkg::*;

  rx_state_e           state;
  logic [2:0]          phase;
  logic [`ELINK_W-1:0] pair;
  // newest pair enters at the top, oldest sits in bits 1:0
  logic [`SYM_LEN-1:0] win;
  // abcdei fghj, a in the MSB
  logic [`SYM_LEN-1:0] code;
  logic [5:0]          six;
  logic [3:0]          four;
  logic                rd;
  logic                rd_in;
  logic                rd1;
  logic                rd_nxt;
  logic                k28;
  logic [4:0]          x5;
  logic [2:0]          y3;
  logic                ok6;
  logic                ok4;
  logic                bad6;
  logic                bad4;
  rx_sym_t             dec;
  logic                aligned;

  assign pair = swap_bits ? {edata_in[0], edata_in[1]} : edata_in;

  // undo reversal and put a in the MSB in one step
  always_comb
  begin
    for (int i = 0; i < `SYM_LEN; i++)
      code[i] = reverse_10b ? win[i] : win[`SYM_LEN-1-i];
  end

  assign six  = code[9:4];
  assign four = code[3:0];
  // while hunting, trust the form of the incoming 6b group
  assign rd_in = (state == RX_LOCKED) ? rd : ($countones(six) < 3);

  always_comb
  begin
    x5   = '0;
    ok6  = 1'b0;
    bad6 = 1'b0;
    k28  = (six == K28_6B) || (six == ~K28_6B);
    if (k28)
    begin
      x5   = 5'd28;
      ok6  = 1'b1;
      bad6 = rd_in ? (six == K28_6B) : (six == ~K28_6B);
    end
    else
    begin
      for (int x = 0; x < 32; x++)
      begin
        if (six == ENC6_RDM[x])
        begin
          x5   = 5'(x);
          ok6  = 1'b1;
          bad6 = rd_in && sym6_dep(5'(x));
        end
        else if (sym6_dep(5'(x)) && six == ~ENC6_RDM[x])
        begin
          x5   = 5'(x);
          ok6  = 1'b1;
          bad6 = !rd_in;
        end
      end
    end
    rd1 = ($countones(six) == 3) ? rd_in : ($countones(six) > 3);
  end

  // 4b group, an exact form match wins over the wrong-disparity form
  always_comb
  begin
    y3   = '0;
    ok4  = 1'b0;
    bad4 = 1'b0;
    for (int y = 0; y < 8; y++)
    begin
      if (four == (sym4_dep(3'(y)) ? (rd1 ? ~ENC4_RDM[y] : ENC4_RDM[y]) :
                   ((k28 && !rd1) ? ~ENC4_RDM[y] : ENC4_RDM[y])))
      begin
        y3   = 3'(y);
        ok4  = 1'b1;
        bad4 = 1'b0;
      end
      else if (!ok4 && four == (sym4_dep(3'(y)) ? (rd1 ? ENC4_RDM[y] : ~ENC4_RDM[y]) :
                                ((k28 && rd1) ? ~ENC4_RDM[y] : ENC4_RDM[y])))
      begin
        y3   = 3'(y);
        ok4  = 1'b1;
        bad4 = 1'b1;
      end
    end
    // x.7 alternate form
    if (four == (rd1 ? ~A7_4B : A7_4B))
    begin
      y3   = 3'd7;
      ok4  = 1'b1;
      bad4 = 1'b0;
    end
    else if (!ok4 && four == (rd1 ? A7_4B : ~A7_4B))
    begin
      y3   = 3'd7;
      ok4  = 1'b1;
      bad4 = 1'b1;
    end
    rd_nxt = ($countones(four) == 2) ? rd1 : ($countones(four) > 2);
  end

  assign dec.data     = {y3, x5};
  assign dec.ko       = k28;
  assign dec.code_err = !(ok6 && ok4);
  assign dec.disp_err = bad6 || bad4;

  // hunt takes any clean K28.5, then every fifth window
  assign aligned = (state == RX_LOCKED) ? (phase == 3'(`SYM_CYC - 1)) :
                   (dec.ko && dec.data == `K28_5 && !dec.code_err);

  always_ff @(posedge bit_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= RX_HUNT;
      phase    <= '0;
      rd       <= 1'b0;
      rx_valid <= 1'b0;
      win      <= '0;
    end
    else
    begin
      win      <= {pair, win[`SYM_LEN-1:`ELINK_W]};
      rx_valid <= aligned;
      if (aligned)
        rd <= rd_nxt;
      if (state == RX_HUNT)
      begin
        if (aligned)
        begin
          state <= RX_LOCKED;
          phase <= '0;
        end
      end
      else
        phase <= aligned ? 3'd0 : phase + 3'd1;
    end
  end

  always_ff @(posedge bit_clk)
  begin
    if (aligned)
      rx_sym <= dec;
  end

endmodule

// File: design/enc_8b10b.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module enc_8b10b (
  input  logic                bit_clk,
  input  logic                arst_n,
  input  logic                load,
  input  logic [7:0]          din,
  input  logic                k,
  output logic [`SYM_LEN-1:0] dout
);
  import elink_pkg::*;

  logic [4:0]          x5;
  logic [2:0]          y3;
  logic                k28;
  // running disparity, 1 is positive
  logic                rd;
  // disparity between 6b and 4b groups
  logic                rd1;
  logic                rd_nxt;
  logic                use_a7;
  logic [5:0]          c6;
  logic [3:0]          c4;
  // abcdei fghj, a in the MSB
  logic [`SYM_LEN-1:0] code;
  logic [`SYM_LEN-1:0] dout_nxt;

  assign x5  = din[4:0];
  assign y3  = din[7:5];
  assign k28 = k && (x5 == 5'd28);

  always_comb
  begin
    // 6b group, alternate form when rd is positive
    if (k28)
      c6 = rd ? ~K28_6B : K28_6B;
    else if (rd && sym6_dep(x5))
      c6 = ~ENC6_RDM[x5];
    else
      c6 = ENC6_RDM[x5];
    rd1 = ($countones(c6) == 3) ? rd : ($countones(c6) > 3);

    // A7 avoids a run of five equal bits, and all K x.7 use it
    use_a7 = (y3 == 3'd7) &&
             (k || (!rd1 && (x5 inside {5'd17, 5'd18, 5'd20})) ||
              (rd1 && (x5 inside {5'd11, 5'd13, 5'd14})));
    c4 = use_a7 ? A7_4B : ENC4_RDM[y3];
    if (sym4_dep(y3))
      c4 = rd1 ? ~c4 : c4;
    // balanced K groups invert against rd-
    else if (k && !rd1)
      c4 = ~c4;
    rd_nxt = ($countones(c4) == 2) ? rd1 : ($countones(c4) > 2);
  end

  assign code = {c6, c4};

  // bit a goes out first, so it lands in bit 0
  always_comb
  begin
    for (int i = 0; i < `SYM_LEN; i++)
      dout_nxt[i] = code[`SYM_LEN-1-i];
  end

  // one symbol per load, disparity starts negative
  always_ff @(posedge bit_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd   <= 1'b0;
      dout <= '0;
    end
    else if (load)
    begin
      rd   <= rd_nxt;
      dout <= dout_nxt;
    end
  end

endmodule

// File: design/eproc_out_enc.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module eproc_out_enc (
  input  logic                   bit_clk,
  input  logic                   arst_n,
  input  elink_pkg::elink_word_t edata_in,
  input  logic                   data_rdy,
  input  logic                   reverse_10b,
  input  logic                   swap_bits,
  output logic                   get_data_trig,
  output logic [`ELINK_W-1:0]    edata_out
);
  import elink_pkg::*;

  tx_state_e           state;
  // slot 0 carries the request, slot 1 the capture
  logic [2:0]          slot;
  logic                capture;
  elink_word_t         word;
  logic [7:0]          enc_din;
  logic                enc_k;
  logic [`SYM_LEN-1:0] enc_dout;
  logic [`SYM_LEN-1:0] sym;
  logic [2:0]          pair_idx;
  logic [`ELINK_W-1:0] pair;

  // free-running slot counter, request pulse at slot 0
  always_ff @(posedge bit_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state         <= TX_IDLE;
      slot          <= '0;
      get_data_trig <= 1'b0;
    end
    else
    begin
      get_data_trig <= 1'b0;
      if (state == TX_IDLE)
      begin
        state         <= TX_SHIFT;
        get_data_trig <= 1'b1;
      end
      else if (slot == 3'(`SYM_CYC - 1))
      begin
        slot          <= '0;
        get_data_trig <= 1'b1;
      end
      else
        slot <= slot + 3'd1;
    end
  end

  // word sampled the cycle after the request, comma if nothing offered
  assign capture = (state == TX_SHIFT) && (slot == 3'd1);
  assign word    = data_rdy ? edata_in : '{code: CODE_COMMA, data: 8'h00};

  // frame code to byte and K flag
  always_comb
  begin
    enc_k   = 1'b1;
    enc_din = `K28_5;
    case (word.code)
      CODE_DATA:
      begin
        enc_k   = 1'b0;
        enc_din = word.data;
      end
      CODE_SOP: enc_din = `K28_1;
      CODE_EOP: enc_din = `K28_6;
      default:  enc_din = `K28_5;
    endcase
  end

  enc_8b10b u_enc (
    .bit_clk (bit_clk),
    .arst_n  (arst_n),
    .load    (capture),
    .din     (enc_din),
    .k       (enc_k),
    .dout    (enc_dout)
  );

  // MSB first when reversed
  always_comb
  begin
    for (int i = 0; i < `SYM_LEN; i++)
      sym[i] = reverse_10b ? enc_dout[`SYM_LEN-1-i] : enc_dout[i];
  end

  // symbol is out from slot 2 through slot 1 of the next slot
  assign pair_idx  = (slot >= 3'd2) ? slot - 3'd2 : slot + 3'd3;
  assign pair      = sym[pair_idx*`ELINK_W +: `ELINK_W];
  // bit 0 of the line carries the earlier bit unless swapped
  assign edata_out = swap_bits ? {pair[0], pair[1]} : pair;

endmodule

// File: verif/elink_loop_chk.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module elink_loop_chk (
  input logic                bit_clk,
  input logic                arst_n,
  input logic                get_data_trig,
  input logic                rx_valid,
  input logic [`ELINK_W-1:0] edata_out,
  input elink_pkg::rx_sym_t  rx_sym
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // one request per symbol slot
  a_req_spacing: assert property (@(posedge bit_clk) disable iff (!arst_n)
    get_data_trig |=> !get_data_trig [*(`SYM_CYC-1)] ##1 get_data_trig)
  else
  begin
    fail_cnt++;
    $error("get_data_trig not repeating every %0d cycles", `SYM_CYC);
  end

  // once locked, one strobe per slot
  a_rx_spacing: assert property (@(posedge bit_clk) disable iff (!arst_n)
    rx_valid |=> !rx_valid [*(`SYM_CYC-1)] ##1 rx_valid)
  else
  begin
    fail_cnt++;
    $error("rx_valid not repeating every %0d cycles", `SYM_CYC);
  end

  // quiet outputs under reset
  a_reset_state: assert property (@(posedge bit_clk)
    !arst_n |-> !get_data_trig && !rx_valid && (edata_out == '0))
  else
  begin
    fail_cnt++;
    $error("outputs active while arst_n is low");
  end

  // clean decode on every strobe
  a_no_err: assert property (@(posedge bit_clk) disable iff (!arst_n)
    rx_valid |-> !rx_sym.code_err && !rx_sym.disp_err)
  else
  begin
    fail_cnt++;
    $error("decode error flag with rx_valid");
  end

endmodule

bind elink_loop_top elink_loop_chk u_chk (
  .bit_clk       (bit_clk),
  .arst_n        (arst_n),
  .get_data_trig (get_data_trig),
  .rx_valid      (rx_valid),
  .edata_out     (edata_out),
  .rx_sym        (rx_sym)
);

// File: verif/tb_elink_loop.sv
`timescale 1ns/1ps
`include "elink_consts.svh"

module tb_elink_loop;
  import elink_pkg::*;

  localparam int CLK_HALF    = 20;
  localparam int RST_CYC     = 10;
  localparam int IDLE_SLOTS  = 20;
  localparam int N_RAND      = 200;
  localparam int DRAIN_SLOTS = 4;
  // worst case has a gap before every random byte
  localparam int RUN_SLOTS   = IDLE_SLOTS + 6 + 2 * N_RAND + DRAIN_SLOTS;
  localparam int LIMIT_NS    = 4 * (RUN_SLOTS * `SYM_CYC + 2 * RST_CYC) * 2 * CLK_HALF + 20000;
  localparam rx_sym_t COMMA_SYM = '{data: `K28_5, ko: 1'b1, code_err: 1'b0, disp_err: 1'b0};

  logic                bit_clk;
  logic                arst_n;
  elink_word_t         edata_in;
  logic                data_rdy;
  logic                reverse_10b;
  logic                swap_bits;
  logic                get_data_trig;
  logic [`ELINK_W-1:0] edata_out;
  logic                rx_valid;
  rx_sym_t             rx_sym;

  // request seen in the cycle before the current edge
  logic    trig_q;
  logic    synced;
  logic    lock_seen;
  logic    stray_en;
  int      seed;
  int      mismatch_cnt;
  int      other_cnt;
  rx_sym_t exp_q[$];

  elink_loop_top u_dut (
    .bit_clk       (bit_clk),
    .arst_n        (arst_n),
    .edata_in      (edata_in),
    .data_rdy      (data_rdy),
    .reverse_10b   (reverse_10b),
    .swap_bits     (swap_bits),
    .get_data_trig (get_data_trig),
    .edata_out     (edata_out),
    .rx_valid      (rx_valid),
    .rx_sym        (rx_sym)
  );

  always #(CLK_HALF) bit_clk = ~bit_clk;

  always @(negedge bit_clk)
    trig_q = get_data_trig;

  // byte and K flag the link must carry for one slot
  function automatic rx_sym_t expected_sym(input logic rdy, input elink_word_t w);
    rx_sym_t s;
    s = COMMA_SYM;
    if (rdy)
    begin
      case (w.code)
        CODE_DATA:
        begin
          s.ko   = 1'b0;
          s.data = w.data;
        end
        CODE_SOP: s.data = `K28_1;
        CODE_EOP: s.data = `K28_6;
        default:  s.data = `K28_5;
      endcase
    end
    return s;
  endfunction

  // answer one request and maybe offer a stray word after it
  task automatic send_slot(input logic rdy, input elink_word_t w);
    logic [7:0] junk;
    do
      @(posedge bit_clk);
    while (trig_q !== 1'b1);
    data_rdy <= rdy;
    edata_in <= w;
    exp_q.push_back(expected_sym(rdy, w));
    @(posedge bit_clk);
    // unrequested word must never reach the line
    junk = 8'($random(seed));
    data_rdy <= stray_en;
    edata_in <= '{code: CODE_DATA, data: junk};
  endtask

  task automatic apply_reset(input logic rev, input logic swp);
    @(posedge bit_clk);
    arst_n   <= 1'b0;
    data_rdy <= 1'b0;
    @(posedge bit_clk);
    reverse_10b <= rev;
    swap_bits   <= swp;
    repeat (RST_CYC - 1) @(posedge bit_clk);
    arst_n <= 1'b1;
  endtask

  task automatic check_symbol(input rx_sym_t got);
    rx_sym_t exp;
    logic    is_comma;
    is_comma = got.ko && (got.data == `K28_5);
    assert (!got.code_err)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: rx_sym.code_err expected 0 got %0b", $time, got.code_err);
    end
    assert (!got.disp_err)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: rx_sym.disp_err expected 0 got %0b", $time, got.disp_err);
    end
    if (!synced && is_comma)
      lock_seen = 1'b1;
    else
    begin
      if (!synced)
      begin
        // commas sent before the frame are not compared
        while (exp_q.size() > 0 && exp_q[0] == COMMA_SYM)
          void'(exp_q.pop_front());
        synced = 1'b1;
      end
      if (exp_q.size() == 0)
      begin
        // idle fill after the last word
        assert (is_comma)
        else
        begin
          other_cnt++;
          $display("unexpected symbol %02h at %0t with nothing pending", got.data, $time);
        end
      end
      else
      begin
        exp = exp_q.pop_front();
        assert (got.data == exp.data)
        else
        begin
          mismatch_cnt++;
          $display("mismatch at %0t: rx_sym.data expected %02h got %02h",
                   $time, exp.data, got.data);
        end
        assert (got.ko == exp.ko)
        else
        begin
          mismatch_cnt++;
          $display("mismatch at %0t: rx_sym.ko expected %0b got %0b", $time, exp.ko, got.ko);
        end
      end
    end
  endtask

  // receive monitor samples mid-cycle
  always @(negedge bit_clk)
  begin
    if (!arst_n)
    begin
      synced    = 1'b0;
      lock_seen = 1'b0;
      exp_q.delete();
    end
    else if (rx_valid)
      check_symbol(rx_sym);
  end

  task automatic run_pass(input logic rev, input logic swp);
    logic [7:0] b;
    apply_reset(rev, swp);
    stray_en = 1'b0;
    // receiver finds the comma on an idle line
    repeat (IDLE_SLOTS) send_slot(1'b0, '0);
    assert (lock_seen)
    else
    begin
      other_cnt++;
      $display("receiver never locked on idle commas, reverse %0b swap %0b", rev, swp);
    end
    // reference frame
    send_slot(1'b1, '{code: CODE_SOP, data: 8'h00});
    send_slot(1'b1, '{code: CODE_DATA, data: 8'hDE});
    send_slot(1'b1, '{code: CODE_DATA, data: 8'hAD});
    send_slot(1'b1, '{code: CODE_DATA, data: 8'hBE});
    send_slot(1'b1, '{code: CODE_DATA, data: 8'hEF});
    send_slot(1'b1, '{code: CODE_EOP, data: 8'h00});
    stray_en = 1'b1;
    repeat (N_RAND)
    begin
      if (($random(seed) & 3) == 0)
        send_slot(1'b0, '0);
      b = 8'($random(seed));
      send_slot(1'b1, '{code: CODE_DATA, data: b});
    end
    stray_en = 1'b0;
    @(posedge bit_clk);
    data_rdy <= 1'b0;
    while (exp_q.size() > 0)
      @(posedge bit_clk);
    repeat (DRAIN_SLOTS * `SYM_CYC) @(posedge bit_clk);
  endtask

  initial
  begin
    int asrt_cnt;
    bit_clk      = 1'b0;
    arst_n       = 1'b1;
    data_rdy     = 1'b0;
    edata_in     = '0;
    reverse_10b  = 1'b0;
    swap_bits    = 1'b0;
    stray_en     = 1'b0;
    seed         = 32'h6f73_fa9d;
    mismatch_cnt = 0;
    other_cnt    = 0;
    // all four line options
    for (int cfg = 0; cfg < 4; cfg++)
      run_pass(cfg[1], cfg[0]);
    asrt_cnt = u_dut.u_chk.fail_cnt;
    $display("errors: %0d mismatch, %0d other, %0d assertion", mismatch_cnt, other_cnt,
             asrt_cnt);
    if (mismatch_cnt + other_cnt + asrt_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/elink_pkg.sv
design/enc_8b10b.sv
design/eproc_out_enc.sv
design/elink_rx_dec.sv
design/elink_loop_top.sv
verif/elink_loop_chk.sv
verif/tb_elink_loop.sv
